/* fetch_mem_top.f */
icache_pkg.sv
icache.sv
load_read_port.sv
bus_arbiter.sv
burst_ram.sv
fetch_mem_top.sv
fetch_mem_checker.sv
tb_scoreboard.sv
tb_fetch_mem.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and judge the run by its log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_fetch_mem -f fetch_mem_top.f \
  && ./obj_dir/Vtb_fetch_mem > sim.log 2>&1 \
  && ! grep -q "TEST RESULT: FAIL" sim.log \
  && cat sim.log \
  && echo "simulation passed" \
  || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }

/* tb_fetch_mem.sv */
`timescale 1ns/100ps
module tb_fetch_mem;
  import icache_pkg::*;

  localparam int OFFSET_W   = 4;
  localparam int INDEX_W    = 2;
  localparam int MEM_AW     = 8;
  localparam int RAM_LAT    = 2;
  localparam int MAX_GAP    = 4; // longest rready low stretch
  localparam int LINE_BEATS = (1 << OFFSET_W) / 4;
  localparam int N_ROWS     = 16;
  localparam int ROW_CYCLES = LINE_BEATS + RAM_LAT + MAX_GAP + 10;
  // preload and reset come on top of the rows
  localparam int CYCLE_LIMIT = N_ROWS * ROW_CYCLES + (1 << MEM_AW) + 10;

  typedef struct packed {
    logic [ADDR_W-1:0] fetch_addr;
    logic              load_en;
    logic [ADDR_W-1:0] load_addr;
    logic              hit;
  } row_t;

  localparam row_t STIM [N_ROWS] = '{
    '{32'h3000_0100, 1'b0, 32'h0000_0000, 1'b0}, // cold line
    '{32'h3000_0104, 1'b0, 32'h0000_0000, 1'b1},
    '{32'h3000_0108, 1'b1, 32'h0000_0204, 1'b1},
    '{32'h3000_010c, 1'b1, 32'h0000_0318, 1'b1},
    '{32'h3000_0500, 1'b0, 32'h0000_0000, 1'b0}, // same index, new tag
    '{32'h3000_0504, 1'b0, 32'h0000_0000, 1'b1},
    '{32'h3000_0100, 1'b0, 32'h0000_0000, 1'b0}, // evicted earlier
    '{32'h3000_0104, 1'b0, 32'h0000_0000, 1'b1},
    '{32'h0000_0040, 1'b0, 32'h0000_0000, 1'b0}, // bypass region
    '{32'h0000_0040, 1'b1, 32'h3000_0044, 1'b0},
    '{32'h1000_0404, 1'b1, 32'h0000_0400, 1'b0},
    '{32'h3000_0210, 1'b1, 32'h0000_0210, 1'b0},
    '{32'h3000_021c, 1'b1, 32'h3000_0010, 1'b1},
    '{32'h2fff_fffc, 1'b1, 32'h2fff_fff8, 1'b0}, // just below the cached base
    '{32'h3000_0234, 1'b1, 32'h0000_07fc, 1'b0},
    '{32'h3000_0230, 1'b0, 32'h0000_0000, 1'b1}
  };

  logic                  clk;
  logic                  rstn;
  logic                  fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready;
  logic [ADDR_W-1:0]     fetch_araddr;
  logic [WORD_W-1:0]     fetch_rdata;
  logic                  load_arvalid, load_arready, load_rvalid, load_rready;
  logic [ADDR_W-1:0]     load_araddr;
  logic [WORD_W-1:0]     load_rdata;
  logic                  pre_we;
  logic [ADDR_W-1:0]     pre_waddr;
  logic [BUS_DATA_W-1:0] pre_wdata;
  logic [15:0]           hit_count, miss_count;
  logic                  exp_hit;
  int                    err_count;
  int                    rows_done;
  int                    cycles;

  fetch_mem_top #(
    .OFFSET_W(OFFSET_W), .INDEX_W(INDEX_W), .MEM_AW(MEM_AW), .RAM_LAT(RAM_LAT)
  ) i_dut (
    .clk, .rstn,
    .fetch_arvalid, .fetch_arready, .fetch_araddr, .fetch_rvalid, .fetch_rready, .fetch_rdata,
    .load_arvalid, .load_arready, .load_araddr, .load_rvalid, .load_rready, .load_rdata,
    .pre_we, .pre_waddr, .pre_wdata, .hit_count, .miss_count
  );

  tb_scoreboard #(.MEM_AW(MEM_AW)) i_sb (
    .clk, .rstn,
    .fetch_arvalid, .fetch_arready, .fetch_araddr, .fetch_rvalid, .fetch_rready, .fetch_rdata,
    .load_arvalid, .load_arready, .load_araddr, .load_rvalid, .load_rready, .load_rdata,
    .pre_we, .pre_waddr, .pre_wdata, .hit_count, .miss_count,
    .exp_hit, .err_count, .rows_done
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: no progress after %0d cycles, %0d rows finished", cycles, rows_done);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic run_fetch(input logic [ADDR_W-1:0] addr, input logic hit, input int gap);
    fetch_arvalid <= 1'b1;
    fetch_araddr  <= addr;
    exp_hit       <= hit;
    do @(negedge clk); while (!fetch_arready);
    @(posedge clk);
    fetch_arvalid <= 1'b0;
    fetch_rready  <= (gap == 0);
    do @(negedge clk); while (!fetch_rvalid);
    repeat (gap) @(posedge clk); // response held back
    if (gap != 0) fetch_rready <= 1'b1;
    @(posedge clk);
    fetch_rready <= 1'b0;
  endtask

  task automatic run_load(input logic [ADDR_W-1:0] addr, input int gap);
    load_arvalid <= 1'b1;
    load_araddr  <= addr;
    do @(negedge clk); while (!load_arready);
    @(posedge clk);
    load_arvalid <= 1'b0;
    load_rready  <= (gap == 0);
    do @(negedge clk); while (!load_rvalid);
    repeat (gap) @(posedge clk);
    if (gap != 0) load_rready <= 1'b1;
    @(posedge clk);
    load_rready <= 1'b0;
  endtask

  initial begin
    int fetch_gap;
    int load_gap;
    void'($urandom(32'h5e76_56ef));
    rstn          = 1'b0;
    fetch_arvalid = 1'b0;
    fetch_araddr  = '0;
    fetch_rready  = 1'b0;
    load_arvalid  = 1'b0;
    load_araddr   = '0;
    load_rready   = 1'b0;
    pre_we        = 1'b0;
    pre_waddr     = '0;
    pre_wdata     = '0;
    exp_hit       = 1'b0;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    for (int i = 0; i < (1 << MEM_AW); i++) begin
      @(posedge clk);
      pre_we    <= 1'b1;
      pre_waddr <= 32'(i) << 3;
      pre_wdata <= {$urandom, $urandom};
    end
    @(posedge clk);
    pre_we <= 1'b0;
    for (int r = 0; r < N_ROWS; r++) begin
      fetch_gap = $urandom_range(MAX_GAP, 0);
      load_gap  = $urandom_range(MAX_GAP, 0);
      @(posedge clk);
      fork
        run_fetch(STIM[r].fetch_addr, STIM[r].hit, fetch_gap);
        if (STIM[r].load_en) run_load(STIM[r].load_addr, load_gap);
      join
    end
    while (rows_done < N_ROWS) @(posedge clk); // last row report
    $display("rows %0d of %0d, failed checks %0d, hit_count %0d, miss_count %0d",
             rows_done, N_ROWS, err_count, hit_count, miss_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tb_scoreboard.sv */
`timescale 1ns/100ps
module tb_scoreboard #(
  parameter int MEM_AW = 8
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              fetch_arvalid,
  input  logic                              fetch_arready,
  input  logic [icache_pkg::ADDR_W-1:0]     fetch_araddr,
  input  logic                              fetch_rvalid,
  input  logic                              fetch_rready,
  input  logic [icache_pkg::WORD_W-1:0]     fetch_rdata,
  input  logic                              load_arvalid,
  input  logic                              load_arready,
  input  logic [icache_pkg::ADDR_W-1:0]     load_araddr,
  input  logic                              load_rvalid,
  input  logic                              load_rready,
  input  logic [icache_pkg::WORD_W-1:0]     load_rdata,
  input  logic                              pre_we,
  input  logic [icache_pkg::ADDR_W-1:0]     pre_waddr,
  input  logic [icache_pkg::BUS_DATA_W-1:0] pre_wdata,
  input  logic [15:0]                       hit_count,
  input  logic [15:0]                       miss_count,
  input  logic                              exp_hit,
  output int                                err_count,
  output int                                rows_done
);
  import icache_pkg::*;

  logic [BUS_DATA_W-1:0] image [2**MEM_AW]; // copy of the preloaded memory

  logic [ADDR_W-1:0] fetch_addr_q;
  logic [ADDR_W-1:0] load_addr_q;
  logic              hit_q;
  logic              fetch_busy;
  logic              load_busy;
  logic              first_cycle; // cycle right after the fetch address
  logic              check_cnt;
  logic              report_row;
  int                pred_hits;
  int                pred_misses;
  int                row_errs;

  function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
    logic [BUS_DATA_W-1:0] dword;
    dword = image[addr[MEM_AW+2:3]];
    return addr[2] ? dword[63:32] : dword[31:0];
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      err_count++;
      row_errs++;
    end
  endtask

  task automatic flag_error(input string what);
    $display("Error at %0t: %s", $time, what);
    err_count++;
    row_errs++;
  endtask

  always @(negedge clk) begin
    if (pre_we) begin
      image[pre_waddr[MEM_AW+2:3]] = pre_wdata;
    end
    if (!rstn) begin
      fetch_busy  = 1'b0;
      load_busy   = 1'b0;
      first_cycle = 1'b0;
      check_cnt   = 1'b0;
      report_row  = 1'b0;
      pred_hits   = 0;
      pred_misses = 0;
      row_errs    = 0;
      err_count   = 0;
      rows_done   = 0;
    end else begin
      if (check_cnt) begin // counters settle one edge after the response
        compare("hit_count", 32'(hit_count), 32'(pred_hits));
        compare("miss_count", 32'(miss_count), 32'(pred_misses));
        check_cnt = 1'b0;
      end
      if (report_row) begin
        $display("row %0d fetch %h hit %0d: %0d errors", rows_done, fetch_addr_q, hit_q,
                 row_errs);
        rows_done++;
        row_errs   = 0;
        report_row = 1'b0;
      end
      if (first_cycle && hit_q && !fetch_rvalid) begin
        flag_error("cache hit was not answered in the cycle after the address");
      end
      first_cycle = 1'b0;
      if (fetch_arvalid && fetch_arready) begin
        fetch_addr_q = fetch_araddr;
        hit_q        = exp_hit;
        fetch_busy   = 1'b1;
        first_cycle  = 1'b1;
      end
      if (load_arvalid && load_arready) begin
        load_addr_q = load_araddr;
        load_busy   = 1'b1;
      end
      if (fetch_rvalid && fetch_rready) begin
        if (!fetch_busy) begin
          flag_error("fetch response arrived with no fetch outstanding");
        end else begin
          compare("fetch_rdata", fetch_rdata, expected_word(fetch_addr_q));
          if (hit_q) pred_hits++;
          else pred_misses++;
          check_cnt  = 1'b1;
          fetch_busy = 1'b0;
        end
      end
      if (load_rvalid && load_rready) begin
        if (!load_busy) begin
          flag_error("load response arrived with no load outstanding");
        end else begin
          compare("load_rdata", load_rdata, expected_word(load_addr_q));
          load_busy = 1'b0;
        end
      end
      if (((fetch_rvalid && fetch_rready) || (load_rvalid && load_rready)) &&
          !fetch_busy && !load_busy) begin
        report_row = 1'b1;
      end
    end
  end

endmodule

/* fetch_mem_checker.sv */
`timescale 1ns/100ps
module fetch_mem_checker (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          fetch_arready,
  input  logic                          fetch_rvalid,
  input  logic                          fetch_rready,
  input  logic [icache_pkg::WORD_W-1:0] fetch_rdata,
  input  logic                          load_rvalid,
  input  logic                          load_rready,
  input  logic [icache_pkg::WORD_W-1:0] load_rdata,
  input  logic                          ic_bus_arvalid,
  input  logic                          ic_bus_arready,
  input  logic                          ld_bus_arvalid,
  input  logic                          ld_bus_arready,
  input  logic                          mem_arvalid,
  input  logic                          mem_arready,
  input  icache_pkg::ic_state_e         ic_state,
  input  icache_pkg::arb_state_e        arb_state
);
  import icache_pkg::*;

  logic ld_served_last;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ld_served_last <= 1'b1; // icache wins first
    end else if (ic_bus_arvalid && ic_bus_arready) begin
      ld_served_last <= 1'b0;
    end else if (ld_bus_arvalid && ld_bus_arready) begin
      ld_served_last <= 1'b1;
    end
  end

  fetch_resp_hold: assert property (@(posedge clk) disable iff (!rstn)
    fetch_rvalid && !fetch_rready |=> fetch_rvalid && $stable(fetch_rdata))
    else $error("fetch response dropped or changed before fetch_rready");

  load_resp_hold: assert property (@(posedge clk) disable iff (!rstn)
    load_rvalid && !load_rready |=> load_rvalid && $stable(load_rdata))
    else $error("load response dropped or changed before load_rready");

  one_burst_at_a_time: assert property (@(posedge clk) disable iff (!rstn)
    mem_arvalid |-> mem_arready)
    else $error("an address reached the memory while a burst was in flight");

  round_robin_order: assert property (@(posedge clk) disable iff (!rstn)
    ic_bus_arvalid && ld_bus_arvalid && (arb_state == ARB_IDLE) && mem_arready |->
    (ld_served_last ? ic_bus_arready : ld_bus_arready))
    else $error("arbiter did not grant the master that was served longer ago");

  refill_blocks_fetch: assert property (@(posedge clk) disable iff (!rstn)
    (ic_state == IC_REFILL) |-> !fetch_arready)
    else $error("fetch_arready high during a line refill");

endmodule

bind fetch_mem_top fetch_mem_checker u_checker (
  .clk, .rstn,
  .fetch_arready, .fetch_rvalid, .fetch_rready, .fetch_rdata,
  .load_rvalid, .load_rready, .load_rdata,
  .ic_bus_arvalid, .ic_bus_arready, .ld_bus_arvalid, .ld_bus_arready,
  .mem_arvalid, .mem_arready,
  .ic_state(u_icache.state),
  .arb_state(u_arb.state)
);

/* fetch_mem_top.sv */
`timescale 1ns/100ps
module fetch_mem_top #(
  parameter int OFFSET_W = 4,
  parameter int INDEX_W  = 2,
  parameter int MEM_AW   = 8,
  parameter int RAM_LAT  = 2
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              fetch_arvalid,
  output logic                              fetch_arready,
  input  logic [icache_pkg::ADDR_W-1:0]     fetch_araddr,
  output logic                              fetch_rvalid,
  input  logic                              fetch_rready,
  output logic [icache_pkg::WORD_W-1:0]     fetch_rdata,
  input  logic                              load_arvalid,
  output logic                              load_arready,
  input  logic [icache_pkg::ADDR_W-1:0]     load_araddr,
  output logic                              load_rvalid,
  input  logic                              load_rready,
  output logic [icache_pkg::WORD_W-1:0]     load_rdata,
  input  logic                              pre_we,
  input  logic [icache_pkg::ADDR_W-1:0]     pre_waddr,
  input  logic [icache_pkg::BUS_DATA_W-1:0] pre_wdata,
  output logic [15:0]                       hit_count,
  output logic [15:0]                       miss_count
);
  import icache_pkg::*;

  logic                  ic_bus_arvalid, ic_bus_arready, ic_bus_rvalid, ic_bus_rready;
  logic                  ic_bus_rlast;
  logic [ADDR_W-1:0]     ic_bus_araddr;
  logic [7:0]            ic_bus_arlen;
  burst_e                ic_bus_arburst;
  logic [BUS_DATA_W-1:0] ic_bus_rdata;

  logic                  ld_bus_arvalid, ld_bus_arready, ld_bus_rvalid, ld_bus_rready;
  logic                  ld_bus_rlast;
  logic [ADDR_W-1:0]     ld_bus_araddr;
  logic [7:0]            ld_bus_arlen;
  burst_e                ld_bus_arburst;
  logic [BUS_DATA_W-1:0] ld_bus_rdata;

  logic                  mem_arvalid, mem_arready, mem_rvalid, mem_rready, mem_rlast;
  logic [ADDR_W-1:0]     mem_araddr;
  logic [7:0]            mem_arlen;
  burst_e                mem_arburst;
  logic [BUS_DATA_W-1:0] mem_rdata;

  icache #(.OFFSET_W(OFFSET_W), .INDEX_W(INDEX_W)) u_icache (
    .clk, .rstn,
    .fetch_arvalid, .fetch_arready, .fetch_araddr,
    .fetch_rvalid, .fetch_rready, .fetch_rdata,
    .ic_bus_arvalid, .ic_bus_arready, .ic_bus_araddr, .ic_bus_arlen, .ic_bus_arburst,
    .ic_bus_rvalid, .ic_bus_rready, .ic_bus_rdata, .ic_bus_rlast,
    .hit_count, .miss_count
  );

  load_read_port u_load (
    .clk, .rstn,
    .load_arvalid, .load_arready, .load_araddr,
    .load_rvalid, .load_rready, .load_rdata,
    .ld_bus_arvalid, .ld_bus_arready, .ld_bus_araddr, .ld_bus_arlen, .ld_bus_arburst,
    .ld_bus_rvalid, .ld_bus_rready, .ld_bus_rdata, .ld_bus_rlast
  );

  bus_arbiter u_arb (
    .clk, .rstn,
    .ic_bus_arvalid, .ic_bus_arready, .ic_bus_araddr, .ic_bus_arlen, .ic_bus_arburst,
    .ic_bus_rvalid, .ic_bus_rready, .ic_bus_rdata, .ic_bus_rlast,
    .ld_bus_arvalid, .ld_bus_arready, .ld_bus_araddr, .ld_bus_arlen, .ld_bus_arburst,
    .ld_bus_rvalid, .ld_bus_rready, .ld_bus_rdata, .ld_bus_rlast,
    .mem_arvalid, .mem_arready, .mem_araddr, .mem_arlen, .mem_arburst,
    .mem_rvalid, .mem_rready, .mem_rdata, .mem_rlast
  );

  burst_ram #(.MEM_AW(MEM_AW), .RAM_LAT(RAM_LAT)) u_ram (
    .clk, .rstn,
    .mem_arvalid, .mem_arready, .mem_araddr, .mem_arlen, .mem_arburst,
    .mem_rvalid, .mem_rready, .mem_rdata, .mem_rlast,
    .pre_we, .pre_waddr, .pre_wdata
  );

endmodule

/* burst_ram.sv */
`timescale 1ns/100ps
module burst_ram #(
  parameter int MEM_AW  = 8,
  parameter int RAM_LAT = 2
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              mem_arvalid,
  output logic                              mem_arready,
  input  logic [icache_pkg::ADDR_W-1:0]     mem_araddr,
  input  logic [7:0]                        mem_arlen,
  input  icache_pkg::burst_e                mem_arburst,
  output logic                              mem_rvalid,
  input  logic                              mem_rready,
  output logic [icache_pkg::BUS_DATA_W-1:0] mem_rdata,
  output logic                              mem_rlast,
  input  logic                              pre_we,
  input  logic [icache_pkg::ADDR_W-1:0]     pre_waddr,
  input  logic [icache_pkg::BUS_DATA_W-1:0] pre_wdata
);
  import icache_pkg::*;

  localparam int LAT_W = $clog2(RAM_LAT + 1);

  logic [BUS_DATA_W-1:0] mem [2**MEM_AW];

  logic              busy;
  logic [LAT_W-1:0]  lat_cnt;
  logic [7:0]        beats_left;
  logic [ADDR_W-3:0] waddr; // 32-bit word address of the beat
  logic [ADDR_W-3:0] wrap_mask;
  burst_e            burst_q;
  logic [ADDR_W-3:0] waddr_inc;
  logic              ar_hs;
  logic              r_hs;

  assign ar_hs       = mem_arvalid && mem_arready;
  assign r_hs        = mem_rvalid && mem_rready;
  assign mem_arready = !busy;
  assign mem_rvalid  = busy && (lat_cnt == '0);
  assign mem_rlast   = mem_rvalid && (beats_left == 8'd0);
  assign mem_rdata   = mem[waddr[MEM_AW:1]]; // both lanes, master picks by bit 2
  assign waddr_inc   = waddr + 1'b1;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy    <= 1'b0;
      lat_cnt <= '0;
    end else begin
      if (ar_hs) begin
        busy    <= 1'b1;
        lat_cnt <= LAT_W'(RAM_LAT);
      end else if (busy && (lat_cnt != '0)) begin
        lat_cnt <= lat_cnt - 1'b1;
      end
      if (r_hs && mem_rlast) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      waddr      <= mem_araddr[ADDR_W-1:2];
      beats_left <= mem_arlen;
      wrap_mask  <= (ADDR_W-2)'(mem_arlen); // block of arlen+1 words
      burst_q    <= mem_arburst;
    end else if (r_hs && !mem_rlast) begin
      beats_left <= beats_left - 8'd1;
      if (burst_q == BURST_WRAP) begin
        waddr <= (waddr & ~wrap_mask) | (waddr_inc & wrap_mask);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pre_we) begin
      mem[pre_waddr[MEM_AW+2:3]] <= pre_wdata;
    end
  end

endmodule

/* bus_arbiter.sv */
`timescale 1ns/100ps
module bus_arbiter (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              ic_bus_arvalid,
  output logic                              ic_bus_arready,
  input  logic [icache_pkg::ADDR_W-1:0]     ic_bus_araddr,
  input  logic [7:0]                        ic_bus_arlen,
  input  icache_pkg::burst_e                ic_bus_arburst,
  output logic                              ic_bus_rvalid,
  input  logic                              ic_bus_rready,
  output logic [icache_pkg::BUS_DATA_W-1:0] ic_bus_rdata,
  output logic                              ic_bus_rlast,
  input  logic                              ld_bus_arvalid,
  output logic                              ld_bus_arready,
  input  logic [icache_pkg::ADDR_W-1:0]     ld_bus_araddr,
  input  logic [7:0]                        ld_bus_arlen,
  input  icache_pkg::burst_e                ld_bus_arburst,
  output logic                              ld_bus_rvalid,
  input  logic                              ld_bus_rready,
  output logic [icache_pkg::BUS_DATA_W-1:0] ld_bus_rdata,
  output logic                              ld_bus_rlast,
  output logic                              mem_arvalid,
  input  logic                              mem_arready,
  output logic [icache_pkg::ADDR_W-1:0]     mem_araddr,
  output logic [7:0]                        mem_arlen,
  output icache_pkg::burst_e                mem_arburst,
  input  logic                              mem_rvalid,
  output logic                              mem_rready,
  input  logic [icache_pkg::BUS_DATA_W-1:0] mem_rdata,
  input  logic                              mem_rlast
);
  import icache_pkg::*;

  arb_state_e state;
  logic       last_ld; // load was served last
  logic       pick_ic;
  logic       pick_ld;
  logic       idle;

  assign idle    = (state == ARB_IDLE);
  assign pick_ic = ic_bus_arvalid && (!ld_bus_arvalid || last_ld);
  assign pick_ld = ld_bus_arvalid && !pick_ic;

  assign mem_arvalid = idle && (ic_bus_arvalid || ld_bus_arvalid);
  assign mem_araddr  = pick_ic ? ic_bus_araddr  : ld_bus_araddr;
  assign mem_arlen   = pick_ic ? ic_bus_arlen   : ld_bus_arlen;
  assign mem_arburst = pick_ic ? ic_bus_arburst : ld_bus_arburst;

  assign ic_bus_arready = idle && pick_ic && mem_arready;
  assign ld_bus_arready = idle && pick_ld && mem_arready;

  assign ic_bus_rvalid = (state == ARB_ICACHE) && mem_rvalid;
  assign ld_bus_rvalid = (state == ARB_LOAD) && mem_rvalid;
  assign ic_bus_rdata  = mem_rdata;
  assign ld_bus_rdata  = mem_rdata;
  assign ic_bus_rlast  = mem_rlast;
  assign ld_bus_rlast  = mem_rlast;
  assign mem_rready    = ((state == ARB_ICACHE) && ic_bus_rready) ||
                         ((state == ARB_LOAD) && ld_bus_rready);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= ARB_IDLE;
      last_ld <= 1'b1; // icache first after reset
    end else begin
      case (state)
        ARB_IDLE: begin
          if (mem_arvalid && mem_arready) begin
            state   <= pick_ic ? ARB_ICACHE : ARB_LOAD;
            last_ld <= pick_ld;
          end
        end
        ARB_ICACHE, ARB_LOAD: begin
          if (mem_rvalid && mem_rready && mem_rlast) begin
            state <= ARB_IDLE; // grant ends with the last beat
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

endmodule

/* load_read_port.sv */
`timescale 1ns/100ps
module load_read_port (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              load_arvalid,
  output logic                              load_arready,
  input  logic [icache_pkg::ADDR_W-1:0]     load_araddr,
  output logic                              load_rvalid,
  input  logic                              load_rready,
  output logic [icache_pkg::WORD_W-1:0]     load_rdata,
  output logic                              ld_bus_arvalid,
  input  logic                              ld_bus_arready,
  output logic [icache_pkg::ADDR_W-1:0]     ld_bus_araddr,
  output logic [7:0]                        ld_bus_arlen,
  output icache_pkg::burst_e                ld_bus_arburst,
  input  logic                              ld_bus_rvalid,
  output logic                              ld_bus_rready,
  input  logic [icache_pkg::BUS_DATA_W-1:0] ld_bus_rdata,
  input  logic                              ld_bus_rlast
);
  import icache_pkg::*;

  logic              busy; // one load in flight
  logic [ADDR_W-1:0] addr_q;

  assign load_arready   = !busy;
  assign ld_bus_araddr  = addr_q;
  assign ld_bus_arlen   = 8'd0;
  assign ld_bus_arburst = BURST_FIXED;
  assign ld_bus_rready  = load_rready;
  assign load_rvalid    = ld_bus_rvalid;
  assign load_rdata     = addr_q[2] ? ld_bus_rdata[BUS_DATA_W-1 -: WORD_W] :
                                      ld_bus_rdata[WORD_W-1:0];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy           <= 1'b0;
      ld_bus_arvalid <= 1'b0;
    end else begin
      if (load_arvalid && load_arready) begin
        busy           <= 1'b1;
        ld_bus_arvalid <= 1'b1;
      end
      if (ld_bus_arvalid && ld_bus_arready) begin
        ld_bus_arvalid <= 1'b0;
      end
      if (ld_bus_rvalid && ld_bus_rready && ld_bus_rlast) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_arvalid && load_arready) begin
      addr_q <= load_araddr;
    end
  end

endmodule

/* icache.sv */
`timescale 1ns/100ps
module icache #(
  parameter int OFFSET_W = 4,
  parameter int INDEX_W  = 2
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              fetch_arvalid,
  output logic                              fetch_arready,
  input  logic [icache_pkg::ADDR_W-1:0]     fetch_araddr,
  output logic                              fetch_rvalid,
  input  logic                              fetch_rready,
  output logic [icache_pkg::WORD_W-1:0]     fetch_rdata,
  output logic                              ic_bus_arvalid,
  input  logic                              ic_bus_arready,
  output logic [icache_pkg::ADDR_W-1:0]     ic_bus_araddr,
  output logic [7:0]                        ic_bus_arlen,
  output icache_pkg::burst_e                ic_bus_arburst,
  input  logic                              ic_bus_rvalid,
  output logic                              ic_bus_rready,
  input  logic [icache_pkg::BUS_DATA_W-1:0] ic_bus_rdata,
  input  logic                              ic_bus_rlast,
  output logic [15:0]                       hit_count,
  output logic [15:0]                       miss_count
);
  import icache_pkg::*;

  localparam int TAG_W  = ADDR_W - OFFSET_W - INDEX_W;
  localparam int SET_N  = 1 << INDEX_W;
  localparam int WOFF_W = OFFSET_W - 2; // word offset inside a line
  localparam int WPL    = 1 << WOFF_W; // words per line

  logic              line_valid [SET_N];
  logic [TAG_W-1:0]  line_tag   [SET_N];
  logic [WORD_W-1:0] line_data  [SET_N][WPL];

  ic_state_e         state;
  logic [ADDR_W-1:0] addr_q;
  logic [WOFF_W-1:0] fill_off; // word being filled
  logic [WORD_W-1:0] resp_data;

  logic [TAG_W-1:0]   req_tag;
  logic [INDEX_W-1:0] req_index;
  logic [WOFF_W-1:0]  req_off;
  logic [WOFF_W-1:0]  req_next_off;
  logic               req_cacheable;
  logic               req_hit;
  logic               fetch_ar_hs;
  logic               fetch_r_hs;
  logic               bus_r_hs;
  logic [TAG_W-1:0]   q_tag;
  logic [INDEX_W-1:0] q_index;
  logic               beat_lane;
  logic [WORD_W-1:0]  beat_word;

  assign req_tag       = fetch_araddr[ADDR_W-1 -: TAG_W];
  assign req_index     = fetch_araddr[OFFSET_W +: INDEX_W];
  assign req_off       = fetch_araddr[2 +: WOFF_W];
  assign req_next_off  = req_off + 1'b1; // wraps inside the line
  assign req_cacheable = fetch_araddr[ADDR_W-1 -: 4] >= CACHE_BASE;
  assign req_hit       = req_cacheable && line_valid[req_index] &&
                         (line_tag[req_index] == req_tag);

  assign q_tag   = addr_q[ADDR_W-1 -: TAG_W];
  assign q_index = addr_q[OFFSET_W +: INDEX_W];

  assign fetch_ar_hs = fetch_arvalid && fetch_arready;
  assign fetch_r_hs  = fetch_rvalid && fetch_rready;
  assign bus_r_hs    = ic_bus_rvalid && ic_bus_rready;

  // fill_off bit 0 is address bit 2 of the current beat
  assign beat_lane = (state == IC_REFILL) ? fill_off[0] : addr_q[2];
  assign beat_word = beat_lane ? ic_bus_rdata[BUS_DATA_W-1 -: WORD_W] :
                                 ic_bus_rdata[WORD_W-1:0];

  assign fetch_arready  = (state == IC_IDLE);
  assign fetch_rvalid   = (state == IC_HIT_RESP) || (state == IC_MISS_RESP);
  assign fetch_rdata    = resp_data;
  assign ic_bus_rready  = (state == IC_REFILL) || (state == IC_BYPASS); // never stalls the bus
  assign ic_bus_arlen   = (state == IC_REFILL) ? 8'(WPL - 1) : 8'd0;
  assign ic_bus_arburst = (state == IC_REFILL) ? BURST_WRAP : BURST_FIXED;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state          <= IC_IDLE;
      ic_bus_arvalid <= 1'b0;
      hit_count      <= 16'd0;
      miss_count     <= 16'd0;
      for (int i = 0; i < SET_N; i++) begin
        line_valid[i] <= 1'b0;
      end
    end else begin
      if (ic_bus_arvalid && ic_bus_arready) begin
        ic_bus_arvalid <= 1'b0;
      end
      case (state)
        IC_IDLE: begin
          if (fetch_ar_hs) begin
            if (req_hit) begin
              state <= IC_HIT_RESP;
            end else begin
              ic_bus_arvalid <= 1'b1;
              state          <= req_cacheable ? IC_REFILL : IC_BYPASS;
            end
          end
        end
        IC_REFILL: begin
          if (bus_r_hs && ic_bus_rlast) begin
            line_valid[q_index] <= 1'b1;
            state               <= IC_MISS_RESP;
          end
        end
        IC_BYPASS: begin
          if (bus_r_hs && ic_bus_rlast) begin
            state <= IC_MISS_RESP;
          end
        end
        IC_HIT_RESP: begin
          if (fetch_r_hs) begin
            hit_count <= hit_count + 16'd1;
            state     <= IC_IDLE;
          end
        end
        IC_MISS_RESP: begin
          if (fetch_r_hs) begin
            miss_count <= miss_count + 16'd1; // refill and bypass alike
            state      <= IC_IDLE;
          end
        end
        default: state <= IC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_ar_hs) begin
      addr_q   <= fetch_araddr;
      fill_off <= req_next_off;
      if (req_cacheable) begin
        ic_bus_araddr <= {req_tag, req_index, req_next_off, 2'b00}; // requested word comes last
      end else begin
        ic_bus_araddr <= {fetch_araddr[ADDR_W-1:2], 2'b00};
      end
      if (req_hit) begin
        resp_data <= line_data[req_index][req_off];
      end
    end
    if (bus_r_hs) begin
      if (state == IC_REFILL) begin
        line_data[q_index][fill_off] <= beat_word;
        fill_off                     <= fill_off + 1'b1;
        if (ic_bus_rlast) begin
          line_tag[q_index] <= q_tag;
        end
      end
      if (ic_bus_rlast) begin
        resp_data <= beat_word;
      end
    end
  end

endmodule

/* icache_pkg.sv */
package icache_pkg;

  localparam int ADDR_W     = 32;
  localparam int BUS_DATA_W = 64;
  localparam int WORD_W     = 32;

  localparam logic [3:0] CACHE_BASE = 4'h3; // first cacheable nibble

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [2:0] {
    IC_IDLE,
    IC_HIT_RESP,
    IC_REFILL,
    IC_BYPASS,
    IC_MISS_RESP
  } ic_state_e;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ICACHE,
    ARB_LOAD
  } arb_state_e;

endpackage
